// File: common/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

////////////////////
// field widths
////////////////////

// interrupt id from the interrupt controller
`define CTRL_IRQ_ID_W 5
// mcause width, top bit marks an interrupt
`define CTRL_CAUSE_W 6
// encoding widths of the shared enums
`define CTRL_STATE_W 3
`define CTRL_EVENT_W 4
`define CTRL_PC_SEL_W 2
`define CTRL_EXC_SEL_W 2

////////////////////
// trap cause codes
////////////////////

// synchronous exceptions, interrupt bit clear
`define CTRL_CAUSE_ILLEGAL 2
`define CTRL_CAUSE_ECALL_M 11

`endif

// File: common/ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

  ////////////////////
  // select encodings
  ////////////////////

  // fetch pc source, boot must stay zero so requests can be or-ed
  typedef enum logic [`CTRL_PC_SEL_W-1:0] {
    PC_BOOT, PC_JUMP, PC_EXCEPTION, PC_ERET
  } pc_sel_e;

  // exception vector, irq must stay zero as well
  typedef enum logic [`CTRL_EXC_SEL_W-1:0] {
    EXC_PC_IRQ, EXC_PC_ECALL, EXC_PC_ILLINSN
  } exc_pc_sel_e;

  // one event per decode cycle, as seen by the fsm
  typedef enum logic [`CTRL_EVENT_W-1:0] {
    EV_NONE, EV_PLAIN, EV_BRANCH, EV_JUMP, EV_ECALL,
    EV_ILLEGAL, EV_MRET, EV_CSR_STATUS, EV_WFI
  } event_e;

  // controller states
  typedef enum logic [`CTRL_STATE_W-1:0] {
    ST_RESET, ST_BOOT_SET, ST_WAIT_SLEEP, ST_SLEEP,
    ST_FIRST_FETCH, ST_DECODE, ST_FLUSH, ST_IRQ_TAKEN
  } ctrl_state_e;

  ////////////////////
  // bundles
  ////////////////////

  // decoder flags of the instruction sitting in id
  typedef struct packed {
    logic valid;
    logic illegal;
    logic ecall;
    logic mret;
    logic csr_status;
    logic wfi;
    logic branch_set;
    logic jump_set;
    logic branch_in_id;
    logic multicycle;
  } id_flags_t;

  // request from the interrupt controller
  typedef struct packed {
    logic                      req;
    logic [`CTRL_IRQ_ID_W-1:0] id;
  } irq_req_t;

  // pc change request towards the if stage
  typedef struct packed {
    logic        set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_pc_sel;
  } pc_req_t;

  // csr side effects of a trap or a return
  typedef struct packed {
    logic                     save_if;
    logic                     save_id;
    logic                     save_cause;
    logic                     restore_mret;
    logic [`CTRL_CAUSE_W-1:0] cause;
  } csr_ctrl_t;

endpackage

// File: hdl/insn_classifier.sv
`timescale 1ns/1ns

module insn_classifier
  import ctrl_pkg::*;
(
  input  id_flags_t id_i,
  output event_e    kind_o,
  output logic      safe_point_o
);

  // any flag that needs a pipeline flush
  logic trap_any;
  // exactly one of branch or jump
  logic redirect_only;

  assign trap_any = id_i.ecall | id_i.illegal | id_i.mret | id_i.csr_status | id_i.wfi;
  assign redirect_only = id_i.branch_set ^ id_i.jump_set;

  ////////////////////
  // event priority
  ////////////////////

  always_comb
  begin
    kind_o = EV_PLAIN;
    if (!id_i.valid)
    begin
      // empty decode slot
      kind_o = EV_NONE;
    end
    else if (redirect_only && !trap_any)
    begin
      // clean redirect, no trap flag mixed in
      kind_o = id_i.branch_set ? EV_BRANCH : EV_JUMP;
    end
    else if (!id_i.branch_set && !id_i.jump_set && trap_any)
    begin
      // flush kinds, ecall wins over the rest
      if (id_i.ecall)
        kind_o = EV_ECALL;
      else if (id_i.illegal)
        kind_o = EV_ILLEGAL;
      else if (id_i.mret)
        kind_o = EV_MRET;
      else if (id_i.csr_status)
        kind_o = EV_CSR_STATUS;
      else
        kind_o = EV_WFI;
    end
    // conflicting flags fall through as plain, no redirect and no flush
  end

  // interrupts may only be taken between whole instructions
  // a multicycle op or a branch still resolving in id blocks it
  assign safe_point_o = ~id_i.multicycle & ~id_i.branch_in_id;

  ////////////////////
  // checks
  ////////////////////

  // the decoder never marks a wfi slot as a branch
  always_comb
  begin
    if (id_i.valid && id_i.wfi)
      assert (!id_i.branch_set)
      else $error("wfi decoded while branch_set is high");
  end

endmodule

// File: ctrl/ctrl_fsm.sv
`timescale 1ns/1ns

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  logic    fetch_enable_i,
  input  logic    id_ready_i,
  // raw line, only used to wake up
  input  logic    irq_i,
  // request and enable already combined
  input  logic    irq_pending_i,
  input  event_e  kind_i,
  input  logic    safe_point_i,
  input  logic    sleep_i,

  // to the trap unit
  output logic    record_o,
  output logic    fire_o,

  output pc_req_t pc_req_o,
  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    first_fetch_o,
  output logic    is_decoding_o,
  output logic    deassert_we_o,
  output logic    halt_if_o,
  output logic    halt_id_o,
  output logic    exc_kill_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d          = state_q;
    record_o         = 1'b0;
    fire_o           = 1'b0;
    pc_req_o.set     = 1'b0;
    // zero encodings so the top can or both requests
    pc_req_o.pc_sel  = PC_BOOT;
    pc_req_o.exc_pc_sel = EXC_PC_IRQ;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    first_fetch_o    = 1'b0;
    is_decoding_o    = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;
    exc_kill_o       = 1'b0;

    unique case (state_q)
      ST_RESET:
      begin
        // idle until the core is enabled
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = ST_BOOT_SET;
      end

      ST_BOOT_SET:
      begin
        // load the boot address into the fetch pc
        pc_req_o.set    = 1'b1;
        pc_req_o.pc_sel = PC_BOOT;
        state_d         = ST_FIRST_FETCH;
      end

      ST_WAIT_SLEEP:
      begin
        // one settle cycle before sleeping
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ST_SLEEP;
      end

      ST_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on the raw line, even if the irq is masked
        if (irq_i)
          state_d = ST_FIRST_FETCH;
      end

      ST_FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        // stay here while id is not ready
        if (id_ready_i)
          state_d = ST_DECODE;
        // pending interrupt wins over decode
        if (irq_pending_i)
        begin
          state_d   = ST_IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          record_o  = 1'b1;
        end
      end

      ST_DECODE:
      begin
        is_decoding_o = (kind_i != EV_NONE);
        unique case (kind_i)
          EV_BRANCH, EV_JUMP:
          begin
            // redirect in the same cycle
            pc_req_o.set    = 1'b1;
            pc_req_o.pc_sel = PC_JUMP;
          end
          EV_ECALL, EV_ILLEGAL, EV_MRET, EV_CSR_STATUS, EV_WFI:
          begin
            // freeze the front end, trap unit acts in flush
            state_d   = ST_FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            record_o  = 1'b1;
          end
          EV_PLAIN:
          begin
            if (irq_pending_i && safe_point_i)
            begin
              state_d   = ST_IRQ_TAKEN;
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              record_o  = 1'b1;
            end
            else
            begin
              // kill window, the top qualifies it with the raw request
              exc_kill_o = safe_point_i & ~irq_pending_i;
            end
          end
          default:
          begin
            // empty slot, always safe for an interrupt
            if (irq_pending_i)
            begin
              state_d   = ST_IRQ_TAKEN;
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              record_o  = 1'b1;
            end
          end
        endcase
      end

      ST_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        fire_o    = 1'b1;
        // a latched wfi sends us to sleep
        state_d   = sleep_i ? ST_WAIT_SLEEP : ST_DECODE;
      end

      ST_IRQ_TAKEN:
      begin
        // trap unit drives vector, acks and csr saves
        fire_o  = 1'b1;
        state_d = ST_DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ST_RESET;
      end
    endcase
  end

  // stop register writes outside decode and on illegal opcodes
  assign deassert_we_o = ~is_decoding_o | (kind_i == EV_ILLEGAL);

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_RESET;
    else
      state_q <= state_d;
  end

  ////////////////////
  // checks
  ////////////////////

  // asleep only while the wfi record is held, with no redirect and no trap firing
  a_no_pc_in_sleep: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q inside {ST_WAIT_SLEEP, ST_SLEEP}) |-> (sleep_i && !pc_req_o.set && !fire_o)
  ) else $error("pc change or lost wfi record while sleeping");

endmodule

// File: ctrl/trap_unit.sv
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module trap_unit
  import ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      record_i,
  input  event_e                    kind_i,
  input  irq_req_t                  irq_i,
  input  logic                      fire_i,

  output pc_req_t                   pc_req_o,
  output csr_ctrl_t                 csr_o,
  output logic                      exc_ack_o,
  output logic                      irq_ack_o,
  output logic                      sleep_o,
  output logic [`CTRL_IRQ_ID_W-1:0] irq_id_o
);

  // trap record, either a flush kind or an interrupt marker
  logic                      rec_irq_q;
  event_e                    rec_kind_q;
  logic [`CTRL_IRQ_ID_W-1:0] rec_id_q;
  logic                      is_flush_kind;

  assign is_flush_kind = kind_i inside {EV_ECALL, EV_ILLEGAL, EV_MRET, EV_CSR_STATUS, EV_WFI};

  ////////////////////
  // record latch
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rec_irq_q  <= 1'b0;
      rec_kind_q <= EV_NONE;
      rec_id_q   <= '0;
    end
    else if (record_i)
    begin
      rec_irq_q  <= ~is_flush_kind;
      rec_kind_q <= is_flush_kind ? kind_i : EV_NONE;
      // keep the old id across synchronous traps
      if (!is_flush_kind)
        rec_id_q <= irq_i.id;
    end
  end

  ////////////////////
  // record decode
  ////////////////////

  always_comb
  begin
    pc_req_o.set        = 1'b0;
    pc_req_o.pc_sel     = PC_BOOT;
    pc_req_o.exc_pc_sel = EXC_PC_IRQ;
    csr_o               = '0;
    exc_ack_o           = 1'b0;
    irq_ack_o           = 1'b0;

    if (fire_i && rec_irq_q)
    begin
      // interrupt entry, save the fetch pc
      pc_req_o.set     = 1'b1;
      pc_req_o.pc_sel  = PC_EXCEPTION;
      csr_o.save_if    = 1'b1;
      csr_o.save_cause = 1'b1;
      csr_o.cause      = {1'b1, rec_id_q};
      irq_ack_o        = 1'b1;
      exc_ack_o        = 1'b1;
    end
    else if (fire_i)
    begin
      unique case (rec_kind_q)
        EV_ECALL:
        begin
          pc_req_o.set        = 1'b1;
          pc_req_o.pc_sel     = PC_EXCEPTION;
          pc_req_o.exc_pc_sel = EXC_PC_ECALL;
          csr_o.save_id       = 1'b1;
          csr_o.save_cause    = 1'b1;
          csr_o.cause         = `CTRL_CAUSE_W'(`CTRL_CAUSE_ECALL_M);
        end
        EV_ILLEGAL:
        begin
          pc_req_o.set        = 1'b1;
          pc_req_o.pc_sel     = PC_EXCEPTION;
          pc_req_o.exc_pc_sel = EXC_PC_ILLINSN;
          csr_o.save_id       = 1'b1;
          csr_o.save_cause    = 1'b1;
          csr_o.cause         = `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
        end
        EV_MRET:
        begin
          // back to mepc
          pc_req_o.set       = 1'b1;
          pc_req_o.pc_sel    = PC_ERET;
          csr_o.restore_mret = 1'b1;
        end
        // csr status and wfi only flush
        default:
        begin
        end
      endcase
    end
  end

  // an interrupt record always holds EV_NONE as its kind
  assign sleep_o  = (rec_kind_q == EV_WFI);
  assign irq_id_o = rec_id_q;

  ////////////////////
  // checks
  ////////////////////

  // an irq ack comes with the exception entry and follows its record by one cycle
  a_irq_ack_exc: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_ack_o |-> (exc_ack_o && $past(record_i))
  ) else $error("irq_ack without a recorded interrupt");

endmodule

// File: hdl/core_ctrl_top.sv
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module core_ctrl_top
  import ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  input  id_flags_t                 id_i,
  input  logic                      id_ready_i,
  input  logic                      irq_i,
  input  irq_req_t                  irq_req_i,
  input  logic                      m_ie_i,

  output pc_req_t                   pc_req_o,
  output csr_ctrl_t                 csr_o,
  output logic                      instr_req_o,
  output logic                      ctrl_busy_o,
  output logic                      first_fetch_o,
  output logic                      is_decoding_o,
  output logic                      deassert_we_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      exc_kill_o,
  output logic                      exc_ack_o,
  output logic                      irq_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0] irq_id_o
);

  event_e  kind;
  event_e  trap_kind;
  logic    safe_point;
  logic    irq_pending;
  logic    record;
  logic    fire;
  logic    sleep;
  logic    kill_window;
  pc_req_t fsm_pc_req;
  pc_req_t trap_pc_req;

  // masked interrupt request
  assign irq_pending = irq_req_i.req & m_ie_i;

  insn_classifier u_classifier (
    .id_i         (id_i),
    .kind_o       (kind),
    .safe_point_o (safe_point)
  );

  ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready_i),
    .irq_i          (irq_i),
    .irq_pending_i  (irq_pending),
    .kind_i         (kind),
    .safe_point_i   (safe_point),
    .sleep_i        (sleep),
    .record_o       (record),
    .fire_o         (fire),
    .pc_req_o       (fsm_pc_req),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .deassert_we_o  (deassert_we_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .exc_kill_o     (kill_window)
  );

  // outside decode a record can only be an interrupt
  assign trap_kind = is_decoding_o ? kind : EV_NONE;

  trap_unit u_trap (
    .clk       (clk),
    .rst_n     (rst_n),
    .record_i  (record),
    .kind_i    (trap_kind),
    .irq_i     (irq_req_i),
    .fire_i    (fire),
    .pc_req_o  (trap_pc_req),
    .csr_o     (csr_o),
    .exc_ack_o (exc_ack_o),
    .irq_ack_o (irq_ack_o),
    .sleep_o   (sleep),
    .irq_id_o  (irq_id_o)
  );

  // kill only when a request is actually present but masked
  assign exc_kill_o = kill_window & irq_req_i.req;

  // both sides idle at all-zero, never set together
  assign pc_req_o = fsm_pc_req | trap_pc_req;

endmodule

// File: tb/ctrl_tb_model.svh
`ifndef CTRL_TB_MODEL_SVH
`define CTRL_TB_MODEL_SVH

////////////////////
// model state
////////////////////

ctrl_state_e               m_state;
// latched trap record, mirrors what the trap unit must hold
logic                      m_rec_irq;
event_e                    m_rec_kind;
logic [`CTRL_IRQ_ID_W-1:0] m_rec_id;

// predicted outputs of the current cycle
pc_req_t                   exp_pc;
csr_ctrl_t                 exp_csr;
ctrl_bits_t                exp_bits;
logic [`CTRL_IRQ_ID_W-1:0] exp_irq_id;

task automatic model_reset();
  m_state    = ST_RESET;
  m_rec_irq  = 1'b0;
  m_rec_kind = EV_NONE;
  m_rec_id   = '0;
endtask

// one event per slot, conflicting redirect or trap flags give plain
function automatic event_e classify(input id_flags_t f);
  logic traps;
  traps = f.ecall | f.illegal | f.mret | f.csr_status | f.wfi;
  if (!f.valid)
    return EV_NONE;
  if (f.branch_set && !f.jump_set && !traps)
    return EV_BRANCH;
  if (f.jump_set && !f.branch_set && !traps)
    return EV_JUMP;
  if (!f.branch_set && !f.jump_set)
  begin
    // priority order ecall, illegal, mret, csr status, wfi
    if (f.ecall)
      return EV_ECALL;
    if (f.illegal)
      return EV_ILLEGAL;
    if (f.mret)
      return EV_MRET;
    if (f.csr_status)
      return EV_CSR_STATUS;
    if (f.wfi)
      return EV_WFI;
  end
  return EV_PLAIN;
endfunction

// outputs of a firing record, in flush or interrupt-taken
task automatic trap_outputs();
  if (m_rec_irq)
  begin
    exp_pc.set          = 1'b1;
    exp_pc.pc_sel       = PC_EXCEPTION;
    exp_pc.exc_pc_sel   = EXC_PC_IRQ;
    exp_csr.save_if     = 1'b1;
    exp_csr.save_cause  = 1'b1;
    // interrupt cause has the top bit set over the id
    exp_csr.cause       = {1'b1, m_rec_id};
    exp_bits.irq_ack    = 1'b1;
    exp_bits.exc_ack    = 1'b1;
  end
  else if (m_rec_kind == EV_ECALL || m_rec_kind == EV_ILLEGAL)
  begin
    exp_pc.set          = 1'b1;
    exp_pc.pc_sel       = PC_EXCEPTION;
    exp_pc.exc_pc_sel   = (m_rec_kind == EV_ECALL) ? EXC_PC_ECALL : EXC_PC_ILLINSN;
    exp_csr.save_id     = 1'b1;
    exp_csr.save_cause  = 1'b1;
    exp_csr.cause       = (m_rec_kind == EV_ECALL) ? `CTRL_CAUSE_W'(`CTRL_CAUSE_ECALL_M)
                                                   : `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
  end
  else if (m_rec_kind == EV_MRET)
  begin
    exp_pc.set           = 1'b1;
    exp_pc.pc_sel        = PC_ERET;
    exp_csr.restore_mret = 1'b1;
  end
  // csr status and wfi change nothing but the flush
endtask

// predict this cycle's outputs, then advance to the next state
task automatic predict(input stim_t s);
  event_e      ev;
  logic        pending;
  logic        safe;
  logic        take_irq;
  logic        go_flush;
  ctrl_state_e nxt_state;
  ev        = classify(s.id);
  pending   = s.irq_req.req & s.m_ie;
  safe      = ~s.id.multicycle & ~s.id.branch_in_id;
  take_irq  = 1'b0;
  go_flush  = 1'b0;
  nxt_state = m_state;
  exp_pc    = '0;
  exp_csr   = '0;
  exp_bits  = '0;
  exp_bits.instr_req = 1'b1;
  exp_bits.ctrl_busy = 1'b1;
  exp_irq_id         = m_rec_id;

  case (m_state)
    ST_RESET:
    begin
      exp_bits.instr_req = 1'b0;
      if (s.fetch_enable)
        nxt_state = ST_BOOT_SET;
    end
    ST_BOOT_SET:
    begin
      exp_pc.set    = 1'b1;
      exp_pc.pc_sel = PC_BOOT;
      nxt_state     = ST_FIRST_FETCH;
    end
    ST_FIRST_FETCH:
    begin
      exp_bits.first_fetch = 1'b1;
      if (pending)
        take_irq = 1'b1;
      else if (s.id_ready)
        nxt_state = ST_DECODE;
    end
    ST_DECODE:
    begin
      exp_bits.is_decoding = (ev != EV_NONE);
      if (ev == EV_BRANCH || ev == EV_JUMP)
      begin
        exp_pc.set    = 1'b1;
        exp_pc.pc_sel = PC_JUMP;
      end
      else if (ev inside {EV_ECALL, EV_ILLEGAL, EV_MRET, EV_CSR_STATUS, EV_WFI})
        go_flush = 1'b1;
      else if (pending && (ev == EV_NONE || safe))
        take_irq = 1'b1;
      else
        exp_bits.exc_kill = (ev == EV_PLAIN) && safe && s.irq_req.req && !pending;
    end
    ST_FLUSH:
    begin
      exp_bits.halt_if = 1'b1;
      exp_bits.halt_id = 1'b1;
      trap_outputs();
      nxt_state = (!m_rec_irq && m_rec_kind == EV_WFI) ? ST_WAIT_SLEEP : ST_DECODE;
    end
    ST_IRQ_TAKEN:
    begin
      trap_outputs();
      nxt_state = ST_DECODE;
    end
    default:
    begin
      // wait-sleep and sleep look the same from outside
      exp_bits.instr_req = 1'b0;
      exp_bits.ctrl_busy = 1'b0;
      exp_bits.halt_if   = 1'b1;
      exp_bits.halt_id   = 1'b1;
      if (m_state == ST_WAIT_SLEEP)
        nxt_state = ST_SLEEP;
      else if (s.irq)
        nxt_state = ST_FIRST_FETCH;
    end
  endcase

  // a trap or an interrupt freezes the front end and records itself
  if (take_irq || go_flush)
  begin
    exp_bits.halt_if = 1'b1;
    exp_bits.halt_id = 1'b1;
    m_rec_irq        = take_irq;
    m_rec_kind       = take_irq ? EV_NONE : ev;
    if (take_irq)
      m_rec_id = s.irq_req.id;
    nxt_state = take_irq ? ST_IRQ_TAKEN : ST_FLUSH;
  end

  exp_bits.deassert_we = ~exp_bits.is_decoding | (ev == EV_ILLEGAL);
  m_state = nxt_state;
endtask

`endif

// File: tb/ctrl_tb.sv
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module ctrl_tb
  import ctrl_pkg::*;
();

  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 1500;
  localparam int CYCLE_LIMIT     = DIRECTED_CYCLES + RANDOM_CYCLES + 100;

  // all DUT inputs of one cycle
  typedef struct packed {
    logic      fetch_enable;
    id_flags_t id;
    logic      id_ready;
    logic      irq;
    irq_req_t  irq_req;
    logic      m_ie;
  } stim_t;

  // single-bit control outputs
  typedef struct packed {
    logic instr_req;
    logic ctrl_busy;
    logic first_fetch;
    logic is_decoding;
    logic deassert_we;
    logic halt_if;
    logic halt_id;
    logic exc_kill;
    logic exc_ack;
    logic irq_ack;
  } ctrl_bits_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      fetch_enable;
  id_flags_t                 id_flags;
  logic                      id_ready;
  logic                      irq;
  irq_req_t                  irq_req;
  logic                      m_ie;
  pc_req_t                   pc_req;
  csr_ctrl_t                 csr;
  logic                      instr_req;
  logic                      ctrl_busy;
  logic                      first_fetch;
  logic                      is_decoding;
  logic                      deassert_we;
  logic                      halt_if;
  logic                      halt_id;
  logic                      exc_kill;
  logic                      exc_ack;
  logic                      irq_ack;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id;

  int seed;
  int cycles = 0;
  int checks;
  int total_errors;
  int test_errors;

  `include "ctrl_tb_model.svh"

  core_ctrl_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .id_i           (id_flags),
    .id_ready_i     (id_ready),
    .irq_i          (irq),
    .irq_req_i      (irq_req),
    .m_ie_i         (m_ie),
    .pc_req_o       (pc_req),
    .csr_o          (csr),
    .instr_req_o    (instr_req),
    .ctrl_busy_o    (ctrl_busy),
    .first_fetch_o  (first_fetch),
    .is_decoding_o  (is_decoding),
    .deassert_we_o  (deassert_we),
    .halt_if_o      (halt_if),
    .halt_id_o      (halt_id),
    .exc_kill_o     (exc_kill),
    .exc_ack_o      (exc_ack),
    .irq_ack_o      (irq_ack),
    .irq_id_o       (irq_id)
  );

  always #5 clk = ~clk;

  // hard stop on a stuck run
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("run stopped after %0d cycles, the tests never finished", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic compare_pc(input string name, input pc_req_t got, input pc_req_t exp);
    checks++;
    if (got !== exp)
    begin
      test_errors++;
      $display("** Error: %s expected 0x%h got 0x%h at cycle %0d", name, exp, got, cycles);
    end
  endtask

  task automatic compare_csr(input string name, input csr_ctrl_t got, input csr_ctrl_t exp);
    checks++;
    if (got !== exp)
    begin
      test_errors++;
      $display("** Error: %s expected 0x%h got 0x%h at cycle %0d", name, exp, got, cycles);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      test_errors++;
      $display("** Error: %s expected 0x%h got 0x%h at cycle %0d", name, exp, got, cycles);
    end
  endtask

  task automatic compare_id(input string name, input logic [`CTRL_IRQ_ID_W-1:0] got,
                            input logic [`CTRL_IRQ_ID_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      test_errors++;
      $display("** Error: %s expected 0x%h got 0x%h at cycle %0d", name, exp, got, cycles);
    end
  endtask

  task automatic check_outputs();
    compare_pc("pc_req_o", pc_req, exp_pc);
    compare_csr("csr_o", csr, exp_csr);
    compare_bit("instr_req_o", instr_req, exp_bits.instr_req);
    compare_bit("ctrl_busy_o", ctrl_busy, exp_bits.ctrl_busy);
    compare_bit("first_fetch_o", first_fetch, exp_bits.first_fetch);
    compare_bit("is_decoding_o", is_decoding, exp_bits.is_decoding);
    compare_bit("deassert_we_o", deassert_we, exp_bits.deassert_we);
    compare_bit("halt_if_o", halt_if, exp_bits.halt_if);
    compare_bit("halt_id_o", halt_id, exp_bits.halt_id);
    compare_bit("exc_kill_o", exc_kill, exp_bits.exc_kill);
    compare_bit("exc_ack_o", exc_ack, exp_bits.exc_ack);
    compare_bit("irq_ack_o", irq_ack, exp_bits.irq_ack);
    compare_id("irq_id_o", irq_id, exp_irq_id);
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // drive on the falling edge, check once the outputs have settled
  task automatic tick(input stim_t s);
    @(negedge clk);
    fetch_enable = s.fetch_enable;
    id_flags     = s.id;
    id_ready     = s.id_ready;
    irq          = s.irq;
    irq_req      = s.irq_req;
    m_ie         = s.m_ie;
    #1;
    predict(s);
    check_outputs();
  endtask

  function automatic stim_t quiet_stim();
    stim_t s;
    s              = '0;
    s.fetch_enable = 1'b1;
    s.id_ready     = 1'b1;
    return s;
  endfunction

  // valid slot with exactly the flag that stands for ev
  function automatic stim_t insn_stim(input event_e ev);
    stim_t s;
    s          = quiet_stim();
    s.id.valid = (ev != EV_NONE);
    case (ev)
      EV_BRANCH:     s.id.branch_set = 1'b1;
      EV_JUMP:       s.id.jump_set   = 1'b1;
      EV_ECALL:      s.id.ecall      = 1'b1;
      EV_ILLEGAL:    s.id.illegal    = 1'b1;
      EV_MRET:       s.id.mret       = 1'b1;
      EV_CSR_STATUS: s.id.csr_status = 1'b1;
      EV_WFI:        s.id.wfi        = 1'b1;
      default:       s.id.valid      = s.id.valid;
    endcase
    return s;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // mostly valid plain or redirect slots, traps and wfi are rare
  function automatic stim_t random_stim();
    stim_t       s;
    int unsigned pick;
    s                 = '0;
    s.fetch_enable    = (rand_below(8) != 0);
    s.id_ready        = (rand_below(4) != 0);
    s.irq             = (rand_below(8) == 0);
    s.irq_req.req     = (rand_below(12) == 0);
    s.irq_req.id      = `CTRL_IRQ_ID_W'(rand_below(32));
    s.m_ie            = (rand_below(4) != 0);
    s.id.valid        = (rand_below(5) != 0);
    s.id.multicycle   = (rand_below(6) == 0);
    s.id.branch_in_id = (rand_below(8) == 0);
    pick              = rand_below(32);
    if (pick >= 14 && pick < 18)
      s.id.branch_set = 1'b1;
    else if (pick >= 18 && pick < 21)
      s.id.jump_set = 1'b1;
    else if (pick == 21)
      s.id.ecall = 1'b1;
    else if (pick == 22)
      s.id.illegal = 1'b1;
    else if (pick == 23)
      s.id.mret = 1'b1;
    else if (pick == 24)
      s.id.csr_status = 1'b1;
    else if (pick == 25)
      s.id.wfi = 1'b1;
    else if (pick == 26)
    begin
      // redirect conflict
      s.id.branch_set = 1'b1;
      s.id.jump_set   = 1'b1;
    end
    else if (pick == 27)
    begin
      // trap flag mixed with a branch
      s.id.branch_set = 1'b1;
      s.id.ecall      = 1'b1;
    end
    return s;
  endfunction

  task automatic end_test(input string name);
    $display("%s: %0d mismatches", name, test_errors);
    total_errors = total_errors + test_errors;
    test_errors  = 0;
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_boot();
    stim_t s;
    s              = quiet_stim();
    s.fetch_enable = 1'b0;
    repeat (3) tick(s);
    s.fetch_enable = 1'b1;
    s.id_ready     = 1'b0;
    // reset to boot set, boot set to first fetch, then back-pressure
    repeat (4) tick(s);
    s.id_ready = 1'b1;
    tick(s);
    end_test("boot");
  endtask

  task automatic test_redirect();
    stim_t s;
    tick(insn_stim(EV_BRANCH));
    tick(insn_stim(EV_JUMP));
    s             = insn_stim(EV_BRANCH);
    s.id.jump_set = 1'b1;
    tick(s);
    s          = insn_stim(EV_BRANCH);
    s.id.ecall = 1'b1;
    tick(s);
    tick(insn_stim(EV_PLAIN));
    end_test("branch and jump");
  endtask

  task automatic test_sync_traps();
    tick(insn_stim(EV_ECALL));
    tick(quiet_stim());
    tick(insn_stim(EV_ILLEGAL));
    tick(quiet_stim());
    tick(quiet_stim());
    end_test("ecall and illegal");
  endtask

  task automatic test_returns();
    tick(insn_stim(EV_MRET));
    tick(quiet_stim());
    tick(insn_stim(EV_CSR_STATUS));
    tick(quiet_stim());
    end_test("mret and csr status");
  endtask

  task automatic test_interrupts();
    stim_t s;
    s             = insn_stim(EV_PLAIN);
    s.irq_req.req = 1'b1;
    s.irq_req.id  = `CTRL_IRQ_ID_W'(7);
    s.m_ie        = 1'b1;
    tick(s);
    tick(quiet_stim());
    // masked request opens the kill window
    s.m_ie = 1'b0;
    tick(s);
    // not a safe point, nothing taken
    s.m_ie          = 1'b1;
    s.id.multicycle = 1'b1;
    tick(s);
    // empty slot always accepts the interrupt
    s             = insn_stim(EV_NONE);
    s.irq_req.req = 1'b1;
    s.irq_req.id  = `CTRL_IRQ_ID_W'(19);
    s.m_ie        = 1'b1;
    tick(s);
    tick(quiet_stim());
    end_test("interrupts");
  endtask

  task automatic test_sleep();
    stim_t s;
    tick(insn_stim(EV_WFI));
    // flush, wait-sleep, then two cycles asleep
    repeat (4) tick(quiet_stim());
    s     = quiet_stim();
    s.irq = 1'b1;
    tick(s);
    tick(quiet_stim());
    end_test("sleep");
  endtask

  task automatic test_random();
    repeat (RANDOM_CYCLES) tick(random_stim());
    end_test("random");
  endtask

  initial
  begin
    seed         = 54;
    checks       = 0;
    total_errors = 0;
    test_errors  = 0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    id_flags     = '0;
    id_ready     = 1'b0;
    irq          = 1'b0;
    irq_req      = '0;
    m_ie         = 1'b0;
    model_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_boot();
    test_redirect();
    test_sync_traps();
    test_returns();
    test_interrupts();
    test_sleep();
    test_random();

    $display("checks %0d, mismatches %0d", checks, total_errors);
    if (total_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
+incdir+tb
common/ctrl_pkg.sv
hdl/insn_classifier.sv
ctrl/ctrl_fsm.sv
ctrl/trap_unit.sv
hdl/core_ctrl_top.sv
tb/ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ctrl_tb -o ctrl_tb_sim \
  > build.log 2>&1 || { cat build.log; echo "verilator build did not complete"; exit 1; }

./obj_dir/ctrl_tb_sim > sim.log 2>&1
cat sim.log

# fail on the fail message, and also when the pass line never appeared
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
